// ==== design/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    ////////////////////
    // bus timing, counted in system clocks
    typedef logic [8:0]  phase_cnt_t;
    typedef logic [12:0] gap_cnt_t;

    localparam phase_cnt_t scl_period_cycles = 9'd500;
    localparam phase_cnt_t sda_sample_mark   = 9'd124;  // scl high, start/stop edges here
    localparam phase_cnt_t scl_fall_mark     = 9'd249;
    localparam phase_cnt_t sda_change_mark   = 9'd374;  // scl low, master launches data
    localparam gap_cnt_t   gap_cycles        = 13'd5000;

    ////////////////////
    // frame contents
    typedef logic [2:0]  dev_sel_t;
    typedef logic [1:0]  pointer_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    localparam logic [3:0] dev_addr_prefix = 4'b1001;
    localparam logic [5:0] ptr_pad         = 6'b000000;  // upper pointer byte bits
    localparam logic [3:0] byte_bits       = 4'd8;
    localparam logic       dir_write       = 1'b0;
    localparam logic       dir_read        = 1'b1;
    localparam logic       ack_bit         = 1'b0;
    localparam logic       nack_bit        = 1'b1;

    ////////////////////
    // transaction states
    typedef enum logic [3:0] {
        idle, start,
        addr, addr_ack,
        ptr, ptr_ack,
        rd_msb, rd_ack, rd_lsb, rd_nack,
        wr_msb, wr_ack, wr_lsb, wr_ack2,
        stop
    } state_t;

endpackage

`default_nettype wire

// ==== design/i2c_phase_if.sv ====
`default_nettype none

interface i2c_phase_if;

    logic sample_tick;  // scl high midpoint
    logic fall_tick;    // last clock before scl falls
    logic change_tick;  // scl low midpoint
    logic gap_done;     // idle gap elapsed
    logic gap_run;      // sequencer is idle, gap counter enabled

    modport timer (
        output sample_tick, fall_tick, change_tick, gap_done,
        input  gap_run
    );

    modport seq (
        input  sample_tick, fall_tick, change_tick, gap_done,
        output gap_run
    );

endinterface

`default_nettype wire

// ==== design/i2c_shift_if.sv ====
`default_nettype none

interface i2c_shift_if;

    logic               load_byte;    // byte_data into the top of the tx register
    i2c_pkg::byte_t     byte_data;
    logic               load_word;    // wr_word into the tx register
    i2c_pkg::word_t     wr_word;
    logic               shift_out;    // next msb onto sda
    logic               capture;      // sampled sda into the rx register
    logic               sda_force;
    logic               force_value;
    logic               drive_en;     // master owns the line
    logic               sda_in;       // synchronized line level

    modport seq (
        output load_byte, byte_data, load_word, shift_out, capture,
        output sda_force, force_value, drive_en,
        input  sda_in
    );

    modport shift (
        input  load_byte, byte_data, load_word, wr_word, shift_out, capture,
        input  sda_force, force_value, drive_en,
        output sda_in
    );

endinterface

`default_nettype wire

// ==== design/scl_timer.sv ====
`default_nettype none

module scl_timer (
    input  logic        clk,
    input  logic        rst,
    output logic        o_scl,
    i2c_phase_if.timer  phase
);

    i2c_pkg::phase_cnt_t phase_cnt;   // position inside the scl period
    i2c_pkg::gap_cnt_t   gap_cnt;     // clocks spent idle
    logic                period_end;

    assign period_end = (phase_cnt == i2c_pkg::scl_period_cycles - 1'b1);

    ////////////////////
    // free running scl period

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_cnt <= '0;
        end else if (period_end) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_scl <= 1'b0;
        end else if (phase_cnt == i2c_pkg::scl_fall_mark) begin
            o_scl <= 1'b0;                  // low for the second half
        end else if (period_end) begin
            o_scl <= 1'b1;
        end
    end

    assign phase.sample_tick = (phase_cnt == i2c_pkg::sda_sample_mark);
    assign phase.fall_tick   = (phase_cnt == i2c_pkg::scl_fall_mark);
    assign phase.change_tick = (phase_cnt == i2c_pkg::sda_change_mark);

    ////////////////////
    // idle gap between transactions

    assign phase.gap_done = phase.gap_run && (gap_cnt == i2c_pkg::gap_cycles - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            gap_cnt <= '0;
        end else if (!phase.gap_run || phase.gap_done) begin
            gap_cnt <= '0;                  // restart for the next gap
        end else begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/i2c_sequencer.sv ====
`default_nettype none

module i2c_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rd,
    input  i2c_pkg::dev_sel_t   i_dev_sel,
    input  i2c_pkg::pointer_t   i_pointer,
    i2c_phase_if.seq            phase,
    i2c_shift_if.seq            shift
);

    i2c_pkg::state_t state;
    i2c_pkg::state_t state_d;
    logic [3:0]      bit_cnt;      // bits done in the current frame
    logic [3:0]      bit_cnt_d;
    logic            rd_sel;       // transaction type, taken when the gap ends
    logic            rep_start;    // second addressing of a first read
    logic            ptr_sent;     // slave already holds the read pointer
    logic            addr_read;
    i2c_pkg::byte_t  addr_byte;
    i2c_pkg::byte_t  ptr_byte;

    // the ack slot of the state that follows a sent byte
    function automatic i2c_pkg::state_t ack_after(input i2c_pkg::state_t s);
        case (s)
            i2c_pkg::addr:   return i2c_pkg::addr_ack;
            i2c_pkg::ptr:    return i2c_pkg::ptr_ack;
            i2c_pkg::wr_msb: return i2c_pkg::wr_ack;
            default:         return i2c_pkg::wr_ack2;
        endcase
    endfunction

    ////////////////////
    // frame bytes and line ownership

    assign addr_read = rd_sel && (ptr_sent || rep_start);
    assign addr_byte = {i2c_pkg::dev_addr_prefix, i_dev_sel,
                        addr_read ? i2c_pkg::dir_read : i2c_pkg::dir_write};
    assign ptr_byte  = {i2c_pkg::ptr_pad, i_pointer};

    assign phase.gap_run = (state == i2c_pkg::idle);

    assign shift.drive_en = !(state inside {i2c_pkg::addr_ack, i2c_pkg::ptr_ack,
                                            i2c_pkg::rd_msb, i2c_pkg::rd_lsb,
                                            i2c_pkg::wr_ack, i2c_pkg::wr_ack2});

    ////////////////////
    // next state and shifter strobes

    always_comb begin
        state_d           = state;
        bit_cnt_d         = bit_cnt;
        shift.load_byte   = 1'b0;
        shift.byte_data   = ptr_byte;
        shift.load_word   = 1'b0;
        shift.shift_out   = 1'b0;
        shift.capture     = 1'b0;
        shift.sda_force   = 1'b0;
        shift.force_value = 1'b1;

        case (state)
            i2c_pkg::idle: begin
                if (phase.gap_done) state_d = i2c_pkg::start;
            end

            i2c_pkg::start: begin
                if (phase.sample_tick) begin
                    shift.sda_force   = 1'b1;     // sda falls with scl high
                    shift.force_value = 1'b0;
                    shift.load_byte   = 1'b1;
                    shift.byte_data   = addr_byte;
                    bit_cnt_d         = '0;
                    state_d           = i2c_pkg::addr;
                end
            end

            i2c_pkg::addr, i2c_pkg::ptr, i2c_pkg::wr_msb, i2c_pkg::wr_lsb: begin
                if (phase.change_tick) begin
                    if (bit_cnt == i2c_pkg::byte_bits) begin
                        shift.sda_force = 1'b1;   // release high for the ack slot
                        bit_cnt_d       = '0;
                        state_d         = ack_after(state);
                    end else begin
                        shift.shift_out = 1'b1;
                        bit_cnt_d       = bit_cnt + 1'b1;
                    end
                end
            end

            i2c_pkg::addr_ack: begin
                if (phase.fall_tick) begin        // slot ends as scl falls, ack or not
                    if (addr_read) begin
                        state_d = i2c_pkg::rd_msb;
                    end else begin
                        shift.load_byte = 1'b1;   // pointer byte, default byte_data
                        state_d         = i2c_pkg::ptr;
                    end
                end
            end

            i2c_pkg::ptr_ack: begin
                if (phase.fall_tick) begin
                    if (rd_sel) begin
                        state_d = i2c_pkg::start; // repeated start
                    end else begin
                        shift.load_word = 1'b1;
                        state_d         = i2c_pkg::wr_msb;
                    end
                end
            end

            i2c_pkg::wr_ack: begin
                if (phase.fall_tick) state_d = i2c_pkg::wr_lsb;
            end

            i2c_pkg::wr_ack2: begin
                if (phase.fall_tick) state_d = i2c_pkg::stop;
            end

            i2c_pkg::rd_msb, i2c_pkg::rd_lsb: begin
                if (phase.sample_tick && bit_cnt != i2c_pkg::byte_bits) begin
                    shift.capture = 1'b1;
                    bit_cnt_d     = bit_cnt + 1'b1;
                end else if (phase.change_tick && bit_cnt == i2c_pkg::byte_bits) begin
                    shift.sda_force = 1'b1;
                    bit_cnt_d       = '0;
                    if (state == i2c_pkg::rd_msb) begin
                        shift.force_value = i2c_pkg::ack_bit;
                        state_d           = i2c_pkg::rd_ack;
                    end else begin
                        shift.force_value = i2c_pkg::nack_bit;
                        state_d           = i2c_pkg::rd_nack;
                    end
                end
            end

            i2c_pkg::rd_ack: begin
                if (phase.fall_tick) state_d = i2c_pkg::rd_lsb;
            end

            i2c_pkg::rd_nack: begin
                if (phase.fall_tick) state_d = i2c_pkg::stop;
            end

            i2c_pkg::stop: begin
                if (phase.change_tick) begin
                    shift.sda_force   = 1'b1;     // low before scl rises
                    shift.force_value = 1'b0;
                end else if (phase.sample_tick) begin
                    shift.sda_force = 1'b1;       // rise with scl high
                    state_d         = i2c_pkg::idle;
                end
            end

            default: state_d = i2c_pkg::idle;
        endcase
    end

    ////////////////////
    // state and flags

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= i2c_pkg::idle;
            bit_cnt   <= '0;
            rd_sel    <= 1'b0;
            rep_start <= 1'b0;
            ptr_sent  <= 1'b0;
        end else begin
            state   <= state_d;
            bit_cnt <= bit_cnt_d;
            if (phase.gap_done) rd_sel <= i_rd;
            if (state == i2c_pkg::ptr_ack && state_d == i2c_pkg::start) begin
                rep_start <= 1'b1;
            end else if (state == i2c_pkg::stop && state_d == i2c_pkg::idle) begin
                rep_start <= 1'b0;
                ptr_sent  <= ptr_sent | rd_sel;   // reads keep the pointer
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/sda_shifter.sv ====
`default_nettype none

module sda_shifter (
    input  logic            clk,
    input  logic            rst,
    input  logic            i_sda,
    output logic            o_sda_out,
    output logic            o_sda_oe,
    output i2c_pkg::word_t  o_rd_data,
    i2c_shift_if.shift      shift
);

    i2c_pkg::word_t tx_reg;     // msb leaves first
    i2c_pkg::word_t rx_reg;
    logic [1:0]     sda_sync;

    ////////////////////
    // transmit side

    always_ff @(posedge clk) begin
        if (shift.load_word) begin
            tx_reg <= shift.wr_word;
        end else if (shift.load_byte) begin
            tx_reg <= {shift.byte_data, 8'h00};   // byte sits in the top half
        end else if (shift.shift_out) begin
            tx_reg <= {tx_reg[14:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_sda_out <= 1'b1;
            o_sda_oe  <= 1'b1;      // line held high while idle
        end else begin
            if (shift.sda_force) begin
                o_sda_out <= shift.force_value;
            end else if (shift.shift_out) begin
                o_sda_out <= tx_reg[15];
            end
            o_sda_oe <= shift.drive_en;
        end
    end

    ////////////////////
    // receive side

    always_ff @(posedge clk) begin
        if (rst) begin
            sda_sync <= 2'b11;
        end else begin
            sda_sync <= {sda_sync[0], i_sda};
        end
    end

    assign shift.sda_in = sda_sync[1];

    always_ff @(posedge clk) begin
        if (shift.capture) begin
            rx_reg <= {rx_reg[14:0], shift.sda_in};  // msb arrives first
        end
    end

    assign o_rd_data = rx_reg;

endmodule

`default_nettype wire

// ==== design/i2c_temp_master.sv ====
`default_nettype none

module i2c_temp_master (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rd,
    input  i2c_pkg::dev_sel_t   i_dev_sel,
    input  i2c_pkg::pointer_t   i_pointer,
    input  i2c_pkg::word_t      i_wr_data,
    output i2c_pkg::word_t      o_rd_data,
    output logic                o_scl,
    inout  wire                 io_sda
);

    logic sda_out;
    logic sda_oe;

    i2c_phase_if phase_if ();
    i2c_shift_if shift_if ();

    ////////////////////
    // sda pad, open when the slave owns the line

    assign io_sda = sda_oe ? sda_out : 1'bz;

    assign shift_if.wr_word = i_wr_data;   // write word goes straight to the shifter

    scl_timer i_timer (
        .clk   (clk),
        .rst   (rst),
        .o_scl (o_scl),
        .phase (phase_if.timer)
    );

    i2c_sequencer i_seq (
        .clk       (clk),
        .rst       (rst),
        .i_rd      (i_rd),
        .i_dev_sel (i_dev_sel),
        .i_pointer (i_pointer),
        .phase     (phase_if.seq),
        .shift     (shift_if.seq)
    );

    sda_shifter i_shift (
        .clk       (clk),
        .rst       (rst),
        .i_sda     (io_sda),
        .o_sda_out (sda_out),
        .o_sda_oe  (sda_oe),
        .o_rd_data (o_rd_data),
        .shift     (shift_if.shift)
    );

endmodule

`default_nettype wire

// ==== sim/i2c_sensor_model.sv ====
`default_nettype none

module i2c_sensor_model (
    input  logic i_rst,
    input  logic i_scl,
    inout  wire  io_sda
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int drive_delay = 1400;   // ns after scl falls, master has let go by then

    i2c_pkg::word_t regs [4];
    logic           drive_low = 1'b0;
    logic           active = 1'b0;       // between start and stop
    logic           reading = 1'b0;
    logic           rd_half = 1'b0;      // 0 msb byte, 1 lsb byte
    logic           addr_slot = 1'b0;    // slave ack of a read address
    logic [3:0]     bit_idx = '0;        // scl rises seen in the current byte
    int             byte_num = 0;
    i2c_pkg::byte_t shreg = '0;
    i2c_pkg::byte_t wr_msb = '0;
    i2c_pkg::byte_t rd_byte;
    i2c_pkg::word_t rd_word = '0;
    i2c_pkg::pointer_t ptr_reg = '0;

    // records for the testbench
    i2c_pkg::byte_t first_addr = '0;
    i2c_pkg::byte_t last_addr = '0;
    i2c_pkg::byte_t last_ptr = '0;
    i2c_pkg::word_t last_wr = '0;
    logic           ptr_seen = 1'b0;
    logic           mst_ack = 1'b1;
    logic           mst_nack = 1'b0;
    int             txn_starts = 0;
    int             start_count = 0;
    int             stop_count = 0;
    int             line_errors = 0;

    assign io_sda = drive_low ? 1'b0 : 1'bz;
    assign rd_byte = rd_half ? rd_word[7:0] : rd_word[15:8];

    ////////////////////
    // start, stop and line rule
    always @(io_sda) begin
        if (!i_rst) begin
            if (io_sda !== 1'b0 && io_sda !== 1'b1) begin
                line_errors = line_errors + 1;      // contention on the line
            end else if (i_scl === 1'b1) begin
                if (active && bit_idx > 4'd1) line_errors = line_errors + 1;
                if (io_sda == 1'b0) begin
                    if (!active) begin              // new transaction
                        txn_starts = 0;
                        ptr_seen   = 1'b0;
                        mst_ack    = 1'b1;
                        mst_nack   = 1'b0;
                    end
                    active      = 1'b1;
                    reading     = 1'b0;
                    addr_slot   = 1'b0;
                    bit_idx     = '0;
                    byte_num    = 0;
                    txn_starts  = txn_starts + 1;
                    start_count = start_count + 1;
                end else begin
                    active     = 1'b0;
                    reading    = 1'b0;
                    drive_low <= 1'b0;
                    stop_count = stop_count + 1;
                end
            end
        end
    end

    ////////////////////
    // bit sampling
    always @(posedge i_scl) begin
        if (active) begin
            if (bit_idx < 4'd8) begin
                shreg   = {shreg[6:0], io_sda};
                bit_idx = bit_idx + 1'b1;
            end else if (bit_idx == 4'd8) begin
                if (reading && !addr_slot && !rd_half) mst_ack = io_sda;
                else if (reading && !addr_slot) mst_nack = io_sda;
                bit_idx = 4'd9;                     // ninth clock
            end
        end
    end

    always @(negedge i_scl) begin
        if (active) begin
            if (bit_idx == 4'd8) begin
                if (reading) begin
                    drive_low <= 1'b0;              // master owns the ack slot
                end else begin
                    case (byte_num)
                        0: begin
                            if (txn_starts == 1) first_addr = shreg;
                            last_addr = shreg;
                            if (shreg[0]) begin
                                reading   = 1'b1;
                                rd_half   = 1'b0;
                                addr_slot = 1'b1;
                                rd_word   = regs[ptr_reg];
                            end
                        end
                        1: begin
                            last_ptr = shreg;
                            ptr_seen = 1'b1;
                            ptr_reg  = shreg[1:0];
                        end
                        2: wr_msb = shreg;
                        default: begin
                            last_wr = {wr_msb, shreg};
                            regs[ptr_reg] = last_wr;
                        end
                    endcase
                    byte_num = byte_num + 1;
                    drive_low <= #drive_delay 1'b1; // slave ack
                end
            end else if (bit_idx == 4'd9) begin
                bit_idx = '0;
                drive_low <= 1'b0;
                if (addr_slot) addr_slot = 1'b0;    // data bytes follow the address ack
                else if (reading && !rd_half && mst_ack == 1'b0) rd_half = 1'b1;
                else reading = 1'b0;
            end
            if (reading && bit_idx < 4'd8) drive_low <= #drive_delay !rd_byte[3'd7 - bit_idx[2:0]];
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_i2c_temp_master.sv ====
`default_nettype none

module tb_i2c_temp_master;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {kind_write, kind_read_ptr, kind_read_cached} result_kind_t;

    typedef struct packed {
        logic              rd;
        i2c_pkg::dev_sel_t dev_sel;
        i2c_pkg::pointer_t pointer;
        i2c_pkg::word_t    wr_data;
        result_kind_t      kind;
    } stim_t;

    localparam int timeout_cycles = 6 * (int'(i2c_pkg::gap_cycles)
                                    + 45 * int'(i2c_pkg::scl_period_cycles)) + 10000;

    logic              clk = 1'b0;
    logic              rst;
    logic              rd;
    i2c_pkg::dev_sel_t dev_sel;
    i2c_pkg::pointer_t pointer;
    i2c_pkg::word_t    wr_data;
    i2c_pkg::word_t    rd_data;
    logic              scl;
    wire               sda;
    stim_t             stim_table [6];
    i2c_pkg::word_t    exp_regs [4];
    i2c_pkg::pointer_t slave_ptr = '0;   // pointer the sensor currently holds
    logic [15:0]       lfsr_state = 16'd98;
    int                cycle_cnt = 0;

    pullup (sda);

    always #4 clk = ~clk;

    i2c_temp_master i_dut (
        .clk       (clk),
        .rst       (rst),
        .i_rd      (rd),
        .i_dev_sel (dev_sel),
        .i_pointer (pointer),
        .i_wr_data (wr_data),
        .o_rd_data (rd_data),
        .o_scl     (scl),
        .io_sda    (sda)
    );

    i2c_sensor_model i_model (.i_rst(rst), .i_scl(scl), .io_sda(sda));

    ////////////////////
    // helpers
    function automatic i2c_pkg::word_t lfsr_word();
        i2c_pkg::word_t w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = {lfsr_state[14:0], lfsr_state[15] ^ lfsr_state[13]
                          ^ lfsr_state[12] ^ lfsr_state[10]};
            w = {w[14:0], lfsr_state[0]};  // one step per bit
        end
        return w;
    endfunction

    task automatic fail_plain(input string msg);
        $display("%0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input i2c_pkg::byte_t expected,
                              input i2c_pkg::byte_t actual);
        if (actual !== expected) begin
            $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_word(input string name, input i2c_pkg::word_t expected,
                              input i2c_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_for_stop();
        int seen;
        seen = i_model.stop_count;
        while (i_model.stop_count == seen) @(posedge clk);
    endtask

    task automatic check_entry(input stim_t e);
        i2c_pkg::byte_t addr_w;
        i2c_pkg::byte_t addr_r;
        addr_w = {4'b1001, e.dev_sel, 1'b0};
        addr_r = {4'b1001, e.dev_sel, 1'b1};
        if (i_model.line_errors != 0) fail_plain("SDA changed while SCL was high");
        if (e.kind != kind_read_cached) begin
            if (!i_model.ptr_seen) fail_plain("no pointer byte was sent");
            check_byte("first address byte", addr_w, i_model.first_addr);
            check_byte("pointer byte", {6'b000000, e.pointer}, i_model.last_ptr);
            slave_ptr = e.pointer;
        end else if (i_model.ptr_seen) begin
            fail_plain("a later read sent a pointer byte");
        end
        if (e.kind == kind_write) begin
            if (i_model.txn_starts != 1) fail_plain("write held a repeated start");
            check_word("write data", e.wr_data, i_model.last_wr);
            exp_regs[e.pointer] = e.wr_data;
            check_word("sensor register", exp_regs[e.pointer], i_model.regs[e.pointer]);
        end else begin
            if (i_model.txn_starts != ((e.kind == kind_read_ptr) ? 2 : 1)) begin
                fail_plain("wrong number of start conditions in the read");
            end
            check_byte("read address byte", addr_r, i_model.last_addr);
            check_word("o_rd_data", exp_regs[slave_ptr], rd_data);
            if (i_model.mst_ack !== 1'b0) fail_plain("master did not ACK the MSB byte");
            if (i_model.mst_nack !== 1'b1) fail_plain("master did not NACK the LSB byte");
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    ////////////////////
    // stimulus
    initial begin
        rst = 1'b1;
        rd = 1'b0;
        dev_sel = '0;
        pointer = '0;
        wr_data = '0;
        stim_table[0] = '{1'b0, 3'b010, 2'd1, 16'h0, kind_write};
        stim_table[1] = '{1'b0, 3'b010, 2'd2, 16'h0, kind_write};
        stim_table[2] = '{1'b1, 3'b010, 2'd0, 16'h0, kind_read_ptr};
        stim_table[3] = '{1'b1, 3'b101, 2'd3, 16'h0, kind_read_cached};  // pointer ignored
        stim_table[4] = '{1'b0, 3'b101, 2'd3, 16'h0, kind_write};
        stim_table[5] = '{1'b1, 3'b101, 2'd0, 16'h0, kind_read_cached};
        for (int k = 0; k < 4; k++) begin
            exp_regs[k] = lfsr_word();
            i_model.regs[k] = exp_regs[k];
        end
        for (int k = 0; k < 6; k++) begin
            if (stim_table[k].kind == kind_write) stim_table[k].wr_data = lfsr_word();
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (scl !== 1'b0 || sda !== 1'b1) fail_plain("SCL low and SDA high expected after reset");
        for (int k = 0; k < 6; k++) begin
            @(posedge clk);
            rd      <= stim_table[k].rd;
            dev_sel <= stim_table[k].dev_sel;
            pointer <= stim_table[k].pointer;
            wr_data <= stim_table[k].wr_data;
            if (k == 0) begin
                repeat (int'(i2c_pkg::gap_cycles) - 10) @(posedge clk);
                if (i_model.start_count != 0) fail_plain("start came before the idle gap ended");
            end
            wait_for_stop();
            @(negedge clk);
            check_entry(stim_table[k]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/i2c_pkg.sv
design/i2c_phase_if.sv
design/i2c_shift_if.sv
design/scl_timer.sv
design/i2c_sequencer.sv
design/sda_shifter.sv
design/i2c_temp_master.sv
sim/i2c_sensor_model.sv
sim/tb_i2c_temp_master.sv

// ==== Bender.yml ====
package:
  name: i2c_temp_master

sources:
  - design/i2c_pkg.sv
  - design/i2c_phase_if.sv
  - design/i2c_shift_if.sv
  - design/scl_timer.sv
  - design/i2c_sequencer.sv
  - design/sda_shifter.sv
  - design/i2c_temp_master.sv
  - target: simulation
    files:
      - sim/i2c_sensor_model.sv
      - sim/tb_i2c_temp_master.sv
